//--- hw/ppu_host_port.sv
module ppu_host_port (
    input logic clk,
    input logic rst_n,
    input sprite_pkg::axil_req_t axil_req,
    output sprite_pkg::axil_rsp_t axil_rsp,
    input logic [7:0] oam_addr,
    output logic [7:0] oam_data,
    input logic [12:0] chr_addr1,
    input logic [12:0] chr_addr2,
    output logic [7:0] chr_data1,
    output logic [7:0] chr_data2,
    output ppu_timing_pkg::pattern_tbl_t patt_tbl
);
    import ppu_timing_pkg::*;
    import sprite_pkg::*;

    logic [7:0] oam_mem [oam_size];
    logic [7:0] chr_mem [chr_size];

    logic aw_ready_q;
    logic b_valid_q;
    logic ar_ready_q;
    logic r_valid_q;
    logic [31:0] r_data_q;
    logic [31:0] rd_word;
    logic wr_accept;
    logic rd_accept;
    logic wr_is_oam;
    logic wr_is_chr;
    logic rd_is_oam;

    // one write and one read outstanding at most
    assign wr_accept = axil_req.awvalid && axil_req.wvalid && !aw_ready_q && !b_valid_q;
    assign rd_accept = axil_req.arvalid && !ar_ready_q && !r_valid_q;

    assign wr_is_oam = (axil_req.awaddr[13:8] == oam_base[13:8]);
    assign wr_is_chr = (axil_req.awaddr[13] == chr_base[13]);
    assign rd_is_oam = (axil_req.araddr[13:8] == oam_base[13:8]);

    always_comb begin
        rd_word = '0;
        if (rd_is_oam) begin
            rd_word = {24'd0, oam_mem[axil_req.araddr[7:0]]};
        end else if (axil_req.araddr == ctrl_addr) begin
            rd_word = {31'd0, patt_tbl};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            aw_ready_q <= 1'b0;
            b_valid_q <= 1'b0;
            ar_ready_q <= 1'b0;
            r_valid_q <= 1'b0;
            patt_tbl <= LEFT_TBL;
        end else begin
            aw_ready_q <= wr_accept;
            if (aw_ready_q) begin
                b_valid_q <= 1'b1;
            end else if (b_valid_q && axil_req.bready) begin
                b_valid_q <= 1'b0;
            end
            if (wr_accept && axil_req.awaddr == ctrl_addr) begin
                patt_tbl <= pattern_tbl_t'(axil_req.wdata[0]);
            end
            ar_ready_q <= rd_accept;
            if (ar_ready_q) begin
                r_valid_q <= 1'b1;
            end else if (r_valid_q && axil_req.rready) begin
                r_valid_q <= 1'b0;
            end
        end
    end

    // memories and read data
    always_ff @(posedge clk) begin
        if (wr_accept && wr_is_chr) begin
            chr_mem[axil_req.awaddr[12:0]] <= axil_req.wdata[7:0];
        end else if (wr_accept && wr_is_oam) begin
            oam_mem[axil_req.awaddr[7:0]] <= axil_req.wdata[7:0];
        end
        if (ar_ready_q) begin
            r_data_q <= rd_word;
        end
    end

    assign oam_data = oam_mem[oam_addr];
    assign chr_data1 = chr_mem[chr_addr1];
    assign chr_data2 = chr_mem[chr_addr2];

    always_comb begin
        axil_rsp.awready = aw_ready_q;
        axil_rsp.wready = aw_ready_q;
        axil_rsp.bresp = resp_okay;
        axil_rsp.bvalid = b_valid_q;
        axil_rsp.arready = ar_ready_q;
        axil_rsp.rdata = r_data_q;
        axil_rsp.rresp = resp_okay;
        axil_rsp.rvalid = r_valid_q;
    end

endmodule

//--- hw/ppu_timing_pkg.sv
package ppu_timing_pkg;

    // raster size, counted in pixel clocks
    localparam logic [8:0] col_count = 9'd341;
    localparam logic [8:0] row_count = 9'd262;
    localparam logic [8:0] visible_cols = 9'd256;
    localparam logic [8:0] visible_rows = 9'd240;
    localparam logic [8:0] pre_render_row = 9'd261;
    localparam logic [8:0] sprite_height = 9'd8;

    // horizontal phase boundaries
    localparam logic [8:0] sp_pre_first = 9'd257;
    localparam logic [8:0] sp_pre_last = 9'd264;
    localparam logic [8:0] tl_pre_last = 9'd336;

    // pattern table base addresses
    localparam logic [12:0] left_tbl_base = 13'h0000;
    localparam logic [12:0] right_tbl_base = 13'h1000;

    typedef enum logic [2:0] {
        SL_PRE_CYC,
        IDLE_CYC,
        SP_PRE_CYC,
        TL_PRE_CYC,
        GARB_CYC,
        NO_EVAL
    } hs_state_t;

    typedef enum logic {
        LEFT_TBL = 1'b0,
        RIGHT_TBL = 1'b1
    } pattern_tbl_t;

endpackage

//--- hw/scan_timer.sv
module scan_timer (
    input logic clk,
    input logic rst_n,
    output logic clk_en,
    output logic [8:0] row,
    output logic [8:0] col,
    output ppu_timing_pkg::hs_state_t hs_state
);
    import ppu_timing_pkg::*;

    logic [1:0] div_q;
    logic eval_row;

    // pixel clock is master clock / 4
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_q <= 2'd0;
            clk_en <= 1'b0;
        end else begin
            div_q <= div_q + 2'd1;
            clk_en <= (div_q == 2'd3);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col <= 9'd0;
            row <= 9'd0;
        end else if (clk_en) begin
            if (col == col_count - 9'd1) begin
                col <= 9'd0;
                row <= (row == row_count - 9'd1) ? 9'd0 : row + 9'd1;
            end else begin
                col <= col + 9'd1;
            end
        end
    end

    // visible rows plus pre-render row are evaluated
    assign eval_row = (row < visible_rows) || (row == pre_render_row);

    always_comb begin
        if (!eval_row) begin
            hs_state = NO_EVAL;
        end else if (col < visible_cols) begin
            hs_state = SL_PRE_CYC;
        end else if (col < sp_pre_first) begin
            hs_state = IDLE_CYC;
        end else if (col <= sp_pre_last) begin
            hs_state = SP_PRE_CYC;
        end else if (col <= tl_pre_last) begin
            hs_state = TL_PRE_CYC;
        end else begin
            hs_state = GARB_CYC;
        end
    end

endmodule

//--- hw/sp_eval.sv
module sp_eval (
    input logic clk,
    input logic clk_en,
    input logic rst_n,
    input logic [8:0] row,
    input logic [8:0] col,
    input ppu_timing_pkg::hs_state_t hs_state,
    input ppu_timing_pkg::pattern_tbl_t patt_tbl,
    output logic [7:0] oam_addr,
    input logic [7:0] oam_data,
    output logic temp_oam_clr,
    output logic temp_oam_wr,
    output sprite_pkg::second_oam_t temp_oam_wr_data,
    output logic [2:0] temp_oam_rd_idx,
    input sprite_pkg::second_oam_t temp_oam_rd_data,
    output logic sec_oam_clr,
    output logic sec_oam_wr,
    output sprite_pkg::second_oam_t sec_oam_wr_data,
    output logic [12:0] chr_rom_addr1,
    output logic [12:0] chr_rom_addr2,
    input logic [7:0] chr_rom_data1,
    input logic [7:0] chr_rom_data2,
    output logic chr_rom_re
);
    import ppu_timing_pkg::*;
    import sprite_pkg::*;

    second_oam_t cand_q;
    second_oam_t cand_d;
    logic y_hit;
    logic [2:0] tile_line;
    logic [2:0] fine_y;
    logic [12:0] tbl_base;

    // one OAM byte per column, sprite n at columns 4n..4n+3
    assign oam_addr = col[7:0];

    // pre-render row never hits, so row 0 shows nothing
    assign y_hit = ({1'b0, oam_data} <= row)
        && (row < {1'b0, oam_data} + sprite_height)
        && (row != pre_render_row);

    always_comb begin
        cand_d = cand_q;
        temp_oam_wr = 1'b0;
        if (hs_state == SL_PRE_CYC) begin
            case (col[1:0])
                2'd0: begin
                    cand_d = '0;
                    cand_d.active = y_hit;
                    cand_d.y_pos = oam_data;
                end
                2'd1: cand_d.tile_idx = oam_data;
                2'd2: cand_d.attribute = oam_data;
                default: begin
                    cand_d.x_pos = oam_data;
                    temp_oam_wr = cand_q.active;
                end
            endcase
        end
    end

    assign temp_oam_wr_data = cand_d;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cand_q <= '0;
        end else if (clk_en) begin
            cand_q <= cand_d;
        end
    end

    // copy phase walks temp entries 0..7 over columns 257..264
    assign temp_oam_rd_idx = col[2:0] - sp_pre_first[2:0];

    assign tbl_base = (patt_tbl == RIGHT_TBL) ? right_tbl_base : left_tbl_base;
    assign tile_line = row[2:0] - temp_oam_rd_data.y_pos[2:0];
    assign fine_y = temp_oam_rd_data.attribute[7] ? ~tile_line : tile_line;

    // 16 bytes per tile, high plane 8 bytes above the low plane
    assign chr_rom_addr1 = tbl_base + {1'b0, temp_oam_rd_data.tile_idx, 4'b0000}
        + {10'd0, fine_y};
    assign chr_rom_addr2 = chr_rom_addr1 + 13'd8;

    assign sec_oam_clr = (hs_state == IDLE_CYC);
    assign temp_oam_clr = (hs_state == TL_PRE_CYC) || (hs_state == GARB_CYC);
    assign chr_rom_re = (hs_state == SP_PRE_CYC);
    assign sec_oam_wr = chr_rom_re && temp_oam_rd_data.active;

    always_comb begin
        sec_oam_wr_data = temp_oam_rd_data;
        sec_oam_wr_data.bitmap_hi = chr_rom_data2;
        sec_oam_wr_data.bitmap_lo = chr_rom_data1;
    end

endmodule

//--- hw/sprite_line_buf.sv
module sprite_line_buf (
    input logic clk,
    input logic clk_en,
    input logic rst_n,
    input logic clr,
    input logic wr,
    input sprite_pkg::second_oam_t wr_data,
    input logic [sprite_pkg::line_idx_w-1:0] rd_idx,
    output sprite_pkg::second_oam_t rd_data,
    output sprite_pkg::second_oam_t [sprite_pkg::line_sprites-1:0] entries
);
    import sprite_pkg::*;

    second_oam_t [line_sprites-1:0] slot_q;
    logic [line_idx_w:0] fill_q;

    // entries are reset too, the renderer reads them before the first clear
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_q <= '0;
            fill_q <= '0;
        end else if (clk_en) begin
            if (clr) begin
                slot_q <= '0;
                fill_q <= '0;
            end else if (wr && fill_q < (line_idx_w + 1)'(line_sprites)) begin
                slot_q[fill_q[line_idx_w-1:0]] <= wr_data;
                fill_q <= fill_q + 1'b1;
            end
        end
    end

    assign rd_data = slot_q[rd_idx];
    assign entries = slot_q;

endmodule

//--- hw/sprite_pkg.sv
package sprite_pkg;

    localparam int line_sprites = 8;
    localparam int line_idx_w = $clog2(line_sprites);

    // host address map
    localparam int oam_size = 256;
    localparam int chr_size = 8192;
    localparam logic [13:0] oam_base = 14'h0000;
    localparam logic [13:0] ctrl_addr = 14'h0400;
    localparam logic [13:0] chr_base = 14'h2000;
    localparam logic [1:0] resp_okay = 2'b00;

    // attribute bits: 7 vflip, 6 hflip, 5 behind bg, 1:0 palette
    typedef struct packed {
        logic active;
        logic [7:0] y_pos;
        logic [7:0] tile_idx;
        logic [7:0] attribute;
        logic [7:0] x_pos;
        logic [7:0] bitmap_hi;
        logic [7:0] bitmap_lo;
    } second_oam_t;

    typedef struct packed {
        logic valid;
        logic [8:0] row;
        logic [8:0] col;
        logic [1:0] color;
        logic [1:0] palette;
        logic behind;
    } sprite_pixel_t;

    typedef struct packed {
        logic [13:0] awaddr;
        logic awvalid;
        logic [31:0] wdata;
        logic wvalid;
        logic bready;
        logic [13:0] araddr;
        logic arvalid;
        logic rready;
    } axil_req_t;

    typedef struct packed {
        logic awready;
        logic wready;
        logic [1:0] bresp;
        logic bvalid;
        logic arready;
        logic [31:0] rdata;
        logic [1:0] rresp;
        logic rvalid;
    } axil_rsp_t;

endpackage

//--- hw/sprite_renderer.sv
module sprite_renderer (
    input logic clk,
    input logic clk_en,
    input logic rst_n,
    input logic [8:0] row,
    input logic [8:0] col,
    input sprite_pkg::second_oam_t [sprite_pkg::line_sprites-1:0] sec_entries,
    output sprite_pkg::sprite_pixel_t pixel
);
    import ppu_timing_pkg::*;
    import sprite_pkg::*;

    sprite_pixel_t pix_d;

    always_comb begin
        logic [8:0] offset;
        logic [2:0] bit_idx;
        logic [1:0] px;
        pix_d = '0;
        pix_d.valid = (row < visible_rows) && (col < visible_cols);
        pix_d.row = row;
        pix_d.col = col;
        // walk from the highest index so the lowest opaque one wins
        for (int i = line_sprites - 1; i >= 0; i--) begin
            offset = col - {1'b0, sec_entries[i].x_pos};
            // msb is the leftmost pixel unless hflip
            bit_idx = sec_entries[i].attribute[6] ? offset[2:0] : ~offset[2:0];
            px = {sec_entries[i].bitmap_hi[bit_idx], sec_entries[i].bitmap_lo[bit_idx]};
            if (sec_entries[i].active && offset < 9'd8 && px != 2'b00) begin
                pix_d.color = px;
                pix_d.palette = sec_entries[i].attribute[1:0];
                pix_d.behind = sec_entries[i].attribute[5];
            end
        end
    end

    // valid pulses once per pixel clock
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pixel <= '0;
        end else begin
            pixel.valid <= 1'b0;
            if (clk_en) begin
                pixel <= pix_d;
            end
        end
    end

endmodule

//--- hw/sprite_top.sv
module sprite_top (
    input logic clk,
    input logic rst_n,
    input sprite_pkg::axil_req_t axil_req,
    output sprite_pkg::axil_rsp_t axil_rsp,
    output sprite_pkg::sprite_pixel_t pixel
);
    import ppu_timing_pkg::*;
    import sprite_pkg::*;

    logic clk_en;
    logic [8:0] row;
    logic [8:0] col;
    hs_state_t hs_state;
    pattern_tbl_t patt_tbl;
    logic [7:0] oam_addr;
    logic [7:0] oam_data;
    logic [12:0] chr_addr1;
    logic [12:0] chr_addr2;
    logic [7:0] chr_data1;
    logic [7:0] chr_data2;
    logic temp_clr;
    logic temp_wr;
    second_oam_t temp_wr_data;
    logic [line_idx_w-1:0] temp_rd_idx;
    second_oam_t temp_rd_data;
    logic sec_clr;
    logic sec_wr;
    second_oam_t sec_wr_data;
    second_oam_t [line_sprites-1:0] sec_entries;

    ppu_host_port u_host_port (
        .clk(clk), .rst_n(rst_n),
        .axil_req(axil_req), .axil_rsp(axil_rsp),
        .oam_addr(oam_addr), .oam_data(oam_data),
        .chr_addr1(chr_addr1), .chr_addr2(chr_addr2),
        .chr_data1(chr_data1), .chr_data2(chr_data2),
        .patt_tbl(patt_tbl)
    );

    scan_timer u_scan_timer (
        .clk(clk), .rst_n(rst_n), .clk_en(clk_en),
        .row(row), .col(col), .hs_state(hs_state)
    );

    sp_eval u_sp_eval (
        .clk(clk), .clk_en(clk_en), .rst_n(rst_n),
        .row(row), .col(col), .hs_state(hs_state), .patt_tbl(patt_tbl),
        .oam_addr(oam_addr), .oam_data(oam_data),
        .temp_oam_clr(temp_clr), .temp_oam_wr(temp_wr), .temp_oam_wr_data(temp_wr_data),
        .temp_oam_rd_idx(temp_rd_idx), .temp_oam_rd_data(temp_rd_data),
        .sec_oam_clr(sec_clr), .sec_oam_wr(sec_wr), .sec_oam_wr_data(sec_wr_data),
        .chr_rom_addr1(chr_addr1), .chr_rom_addr2(chr_addr2),
        .chr_rom_data1(chr_data1), .chr_rom_data2(chr_data2),
        .chr_rom_re()
    );

    // temp OAM collects the hits of the current row
    sprite_line_buf temp_oam (
        .clk(clk), .clk_en(clk_en), .rst_n(rst_n),
        .clr(temp_clr), .wr(temp_wr), .wr_data(temp_wr_data),
        .rd_idx(temp_rd_idx), .rd_data(temp_rd_data), .entries()
    );

    // secondary OAM feeds the renderer on the next row
    sprite_line_buf sec_oam (
        .clk(clk), .clk_en(clk_en), .rst_n(rst_n),
        .clr(sec_clr), .wr(sec_wr), .wr_data(sec_wr_data),
        .rd_idx('0), .rd_data(), .entries(sec_entries)
    );

    sprite_renderer u_renderer (
        .clk(clk), .clk_en(clk_en), .rst_n(rst_n),
        .row(row), .col(col), .sec_entries(sec_entries), .pixel(pixel)
    );

endmodule

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, and fail when the log holds the fail message
cd "$(dirname "$0")" \
    && verilator --binary --timing -Wno-fatal --top-module tb_sprite_top \
        -f sources.f -o tb_sprite_top \
    && ./obj_dir/tb_sprite_top > sim.log \
    ; cat sim.log 2>/dev/null \
    ; test -f sim.log && ! grep -q ">>> FAIL" sim.log \
    || { echo "simulation failed, see sim.log"; exit 1; }

//--- sources.f
hw/ppu_timing_pkg.sv
hw/sprite_pkg.sv
hw/ppu_host_port.sv
hw/scan_timer.sv
hw/sp_eval.sv
hw/sprite_line_buf.sv
hw/sprite_renderer.sv
hw/sprite_top.sv
tests/tb_sprite_top.sv

//--- tests/tb_sprite_top.sv
module tb_sprite_top;
    import ppu_timing_pkg::*;
    import sprite_pkg::*;

    localparam int frame_clks = 341 * 262 * 4;
    localparam int frame_tests = 6;

    logic clk;
    logic rst_n;
    axil_req_t req;
    axil_rsp_t rsp;
    sprite_pixel_t px;

    logic [31:0] rng_state = 32'h4324;
    logic [7:0] oam_model [oam_size];
    logic [7:0] chr_model [chr_size];
    logic tbl_model;
    int err_cnt;
    int tests_run;
    int tests_failed;

    sprite_top dut (
        .clk(clk), .rst_n(rst_n), .axil_req(req), .axil_rsp(rsp), .pixel(px)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // frame 0 for register access, one frame per frame test, one frame of margin
    initial begin
        #(64'(frame_tests + 2) * frame_clks * 100);
        $display("watchdog expired before all frames were checked");
        $display(">>> FAIL");
        $finish;
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] got);
        err_cnt++;
        $display("FAILED at %0t: %s expected 0x%0h got 0x%0h", $time, name, exp, got);
    endtask

    task automatic check_pixel(input sprite_pixel_t got, input sprite_pixel_t exp);
        if (got.row !== exp.row) report_mismatch("pixel.row", 32'(exp.row), 32'(got.row));
        if (got.col !== exp.col) report_mismatch("pixel.col", 32'(exp.col), 32'(got.col));
        if (got.color !== exp.color) begin
            report_mismatch("pixel.color", 32'(exp.color), 32'(got.color));
        end
        if (got.palette !== exp.palette) begin
            report_mismatch("pixel.palette", 32'(exp.palette), 32'(got.palette));
        end
        if (got.behind !== exp.behind) begin
            report_mismatch("pixel.behind", 32'(exp.behind), 32'(got.behind));
        end
    endtask

    task automatic check_rsp(input axil_rsp_t got, input axil_rsp_t exp, input bit is_read);
        if (is_read) begin
            if (got.rvalid !== exp.rvalid) begin
                report_mismatch("rvalid", 32'(exp.rvalid), 32'(got.rvalid));
            end
            if (got.rresp !== exp.rresp) begin
                report_mismatch("rresp", 32'(exp.rresp), 32'(got.rresp));
            end
            if (got.rdata !== exp.rdata) report_mismatch("rdata", exp.rdata, got.rdata);
        end else begin
            if (got.bvalid !== exp.bvalid) begin
                report_mismatch("bvalid", 32'(exp.bvalid), 32'(got.bvalid));
            end
            if (got.bresp !== exp.bresp) begin
                report_mismatch("bresp", 32'(exp.bresp), 32'(got.bresp));
            end
        end
    endtask

    // sel picks 0 awready with wready, 1 bvalid, 2 arready, 3 rvalid
    task automatic wait_rsp(input int sel, input string what);
        int n;
        logic seen;
        n = 0;
        seen = 1'b0;
        while (!seen && n < 64) begin
            case (sel)
                0: seen = rsp.awready && rsp.wready;
                1: seen = rsp.bvalid;
                2: seen = rsp.arready;
                default: seen = rsp.rvalid;
            endcase
            if (!seen) begin
                @(negedge clk);
                n++;
            end
        end
        if (!seen) begin
            err_cnt++;
            $display("timed out at %0t waiting for %s", $time, what);
        end
    endtask

    task automatic axi_write(input logic [13:0] addr, input logic [7:0] data);
        axil_rsp_t exp;
        exp = '0;
        exp.bvalid = 1'b1;
        exp.bresp = resp_okay;
        @(negedge clk);
        req.awaddr = addr;
        req.awvalid = 1'b1;
        req.wdata = {24'd0, data};
        req.wvalid = 1'b1;
        wait_rsp(0, "awready and wready");
        // valid stays up through the handshake edge
        @(negedge clk);
        req.awvalid = 1'b0;
        req.wvalid = 1'b0;
        wait_rsp(1, "bvalid");
        // response has to hold while bready is late
        repeat (next_rand() % 4) @(negedge clk);
        check_rsp(rsp, exp, 1'b0);
        req.bready = 1'b1;
        @(negedge clk);
        req.bready = 1'b0;
        if (addr[13]) begin
            chr_model[addr[12:0]] = data;
        end else if (addr[13:8] == 6'd0) begin
            oam_model[addr[7:0]] = data;
        end else if (addr == ctrl_addr) begin
            tbl_model = data[0];
        end
    endtask

    task automatic axi_read(input logic [13:0] addr, input logic [31:0] data);
        axil_rsp_t exp;
        exp = '0;
        exp.rvalid = 1'b1;
        exp.rresp = resp_okay;
        exp.rdata = data;
        @(negedge clk);
        req.araddr = addr;
        req.arvalid = 1'b1;
        wait_rsp(2, "arready");
        @(negedge clk);
        req.arvalid = 1'b0;
        wait_rsp(3, "rvalid");
        repeat (next_rand() % 4) @(negedge clk);
        check_rsp(rsp, exp, 1'b1);
        req.rready = 1'b1;
        @(negedge clk);
        req.rready = 1'b0;
    endtask

    // sprites hitting row r-1 are drawn on row r, lowest index first
    function automatic sprite_pixel_t expected_pixel(input int r, input int c);
        sprite_pixel_t p;
        int hits;
        int y;
        int x;
        int line;
        int bit_pos;
        int addr;
        logic [7:0] att;
        logic [1:0] color;
        p = '0;
        p.valid = 1'b1;
        p.row = 9'(r);
        p.col = 9'(c);
        hits = 0;
        if (r == 0) return p;
        for (int n = 0; n < 64 && hits < 8; n++) begin
            y = int'(oam_model[4 * n]);
            if (y <= r - 1 && r - 1 < y + 8) begin
                hits++;
                att = oam_model[4 * n + 2];
                x = int'(oam_model[4 * n + 3]);
                line = att[7] ? 7 - (r - 1 - y) : r - 1 - y;
                addr = int'(tbl_model) * 4096 + int'(oam_model[4 * n + 1]) * 16 + line;
                bit_pos = att[6] ? c - x : 7 - (c - x);
                if (c >= x && c - x < 8) begin
                    color = {chr_model[addr + 8][bit_pos], chr_model[addr][bit_pos]};
                    if (color != 2'd0) begin
                        p.color = color;
                        p.palette = att[1:0];
                        p.behind = att[5];
                        return p;
                    end
                end
            end
        end
        return p;
    endfunction

    task automatic end_test(input string name, input int base_err);
        tests_run++;
        if (err_cnt != base_err) begin
            tests_failed++;
            $display("test %s: failed with %0d mismatches", name, err_cnt - base_err);
        end else begin
            $display("test %s: passed", name);
        end
    endtask

    task automatic wait_frame_end();
        while (!(px.valid && px.row == 9'd239 && px.col == 9'd255)) begin
            @(negedge clk);
        end
    endtask

    task automatic check_frame();
        int r;
        int c;
        r = 0;
        c = 0;
        while (r < 240) begin
            @(negedge clk);
            if (px.valid) begin
                check_pixel(px, expected_pixel(r, c));
                if (r == 0 && px.color != 2'd0) begin
                    err_cnt++;
                    $display("sprite pixel shown on row 0 at col %0d", c);
                end
                c++;
                if (c == 256) begin
                    c = 0;
                    r++;
                end
            end
        end
    endtask

    task automatic place_sprite(input int n, input logic [7:0] y, input logic [7:0] attr,
                                input logic [7:0] x);
        logic [7:0] tile;
        tile = 8'(next_rand());
        axi_write(14'(4 * n), y);
        axi_write(14'(4 * n + 1), tile);
        axi_write(14'(4 * n + 2), attr);
        axi_write(14'(4 * n + 3), x);
        // fresh bitmap for both planes of the tile
        for (int i = 0; i < 16; i++) begin
            axi_write(14'(int'(chr_base) + int'(tbl_model) * 4096 + int'(tile) * 16 + i),
                      8'(next_rand()));
        end
    endtask

    task automatic hide_all();
        for (int n = 0; n < 64; n++) begin
            axi_write(14'(4 * n), 8'hf8);
            axi_write(14'(4 * n + 1), 8'(next_rand()));
            axi_write(14'(4 * n + 2), 8'(next_rand()));
            axi_write(14'(4 * n + 3), 8'(next_rand()));
        end
    endtask

    task automatic reg_test();
        logic [7:0] addrs [16];
        int base_err;
        base_err = err_cnt;
        for (int i = 0; i < 16; i++) begin
            addrs[i] = 8'(next_rand());
            axi_write({6'd0, addrs[i]}, 8'(next_rand()));
        end
        for (int i = 0; i < 16; i++) begin
            axi_read({6'd0, addrs[i]}, {24'd0, oam_model[addrs[i]]});
        end
        axi_write(ctrl_addr, 8'(next_rand()));
        axi_read(ctrl_addr, {31'd0, tbl_model});
        // unmapped writes are dropped and unmapped reads return zero
        axi_write(14'h0800, 8'(next_rand()));
        axi_read(14'h0800, 32'd0);
        axi_read(14'h0404, 32'd0);
        axi_read(14'(int'(chr_base) + int'(next_rand() % 8192)), 32'd0);
        axi_read(ctrl_addr, {31'd0, tbl_model});
        end_test("register access", base_err);
    endtask

    // writes go in the vertical blank after row 239
    task automatic frame_test(input string name, input int kind);
        int base_err;
        logic [7:0] y0;
        base_err = err_cnt;
        wait_frame_end();
        axi_write(ctrl_addr, 8'(next_rand() & 32'd1));
        hide_all();
        case (kind)
            0: place_sprite(next_rand() % 64, 8'(next_rand() % 240), 8'(next_rand()) & 8'h23,
                            8'(next_rand()));
            1: begin
                for (int i = 0; i < 4; i++) begin
                    place_sprite(next_rand() % 64, 8'(next_rand() % 240),
                                 8'(next_rand()) & 8'he3, 8'(next_rand()));
                end
            end
            2: begin
                // twelve sprites crowded into one band of rows
                y0 = 8'(16 + next_rand() % 200);
                for (int i = 0; i < 12; i++) begin
                    place_sprite(i * 5, y0 + 8'(next_rand() % 4), 8'(next_rand()) & 8'he3,
                                 8'(96 + next_rand() % 24));
                end
            end
            default: begin
                place_sprite(0, 8'd0, 8'(next_rand()) & 8'he3, 8'(next_rand()));
                place_sprite(1, 8'd231, 8'(next_rand()) & 8'he3, 8'(next_rand()));
                place_sprite(2, 8'(next_rand() % 240), 8'(next_rand()) & 8'he3,
                             8'(next_rand()));
                // y 255 spans the pre-render row but never reaches row 0
                place_sprite(3, 8'd255, 8'(next_rand()) & 8'he3, 8'(next_rand() % 248));
            end
        endcase
        check_frame();
        end_test(name, base_err);
    endtask

    initial begin
        rst_n = 1'b0;
        req = '0;
        tbl_model = 1'b0;
        err_cnt = 0;
        tests_run = 0;
        tests_failed = 0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        reg_test();
        frame_test("single sprite a", 0);
        frame_test("single sprite b", 0);
        frame_test("flips a", 1);
        frame_test("flips b", 1);
        frame_test("eight-sprite limit", 2);
        frame_test("row clearing", 3);
        $display("tests run %0d, failed %0d, mismatches %0d", tests_run, tests_failed, err_cnt);
        if (err_cnt == 0 && tests_failed == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
